//--- Makefile
TOP := tb_console

.PHONY: sim clean

# Build and run; the status comes from the search for the pass message.
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir

//--- hdl/console_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module console_buffer #(
  parameter int DEPTH = console_pkg::COLS_DEF * console_pkg::ROWS_DEF
) (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       cyc_i,
  input  logic                       stb_i,
  input  logic                       we_i,
  input  logic [wb_pkg::ADR_W-1:0]   adr_i,
  input  logic [wb_pkg::SEL_W-1:0]   sel_i,
  input  logic [wb_pkg::DAT_W-1:0]   dat_i,
  output logic                       ack_o,
  output logic [wb_pkg::DAT_W-1:0]   dat_o
);

  import wb_pkg::*;
  import console_pkg::*;

  localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // One memory per byte lane, all indexed by the same word address.
  logic [7:0]       mem [SEL_W][DEPTH];
  logic [IDX_W-1:0] idx;
  logic             accept;
  logic             ack_q;
  cell_t            wr_word;
  cell_t            rd_word;

  assign accept  = cyc_i & stb_i;
  assign idx     = adr_i[WORD_LSB +: IDX_W];
  assign wr_word = dat_i;

  // Reads return the old contents when a write hits the same word.
  always_ff @(posedge clk)
  begin
    for (int lane = 0; lane < SEL_W; lane++)
    begin
      if (accept && we_i && sel_i[lane])
      begin
        mem[lane][idx] <= wr_word.bytes[lane];
      end
      if (accept)
      begin
        rd_word.bytes[lane] <= mem[lane][idx];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      ack_q <= 1'b0;
    end
    else
    begin
      ack_q <= accept;
    end
  end

  assign ack_o = ack_q;
  assign dat_o = rd_word;

  // A master must never address past the end of the screen.
  a_adr_range: assert property (@(posedge clk) disable iff (!rst_n_i)
    (cyc_i && stb_i) |-> (adr_i[ADR_W-1:WORD_LSB] < DEPTH));

endmodule

`default_nettype wire

//--- hdl/console_pkg.sv
`default_nettype none

package console_pkg;

  // Screen geometry used when the top level is not overridden.
  localparam int COLS_DEF = 20;
  localparam int ROWS_DEF = 16;

  localparam int CELL_BYTES = 4;

  // ====================
  // Cell word layout
  // ====================

  // Field view of one cell. The glyph sits in the lowest byte lane.
  typedef struct packed {
    logic [7:0] flags;
    logic [7:0] bg;
    logic [7:0] fg;
    logic [7:0] glyph;
  } cell_fields_t;

  // The same word seen as byte lanes or as named fields.
  typedef union packed {
    logic [CELL_BYTES-1:0][7:0] bytes;
    cell_fields_t               fields;
  } cell_t;

endpackage

`default_nettype wire

//--- hdl/console_top.sv
`timescale 1ns/1ps
`default_nettype none

module console_top #(
  parameter  int COLS  = console_pkg::COLS_DEF,
  parameter  int ROWS  = console_pkg::ROWS_DEF,
  localparam int COL_W = (COLS > 1) ? $clog2(COLS) : 1,
  localparam int ROW_W = (ROWS > 1) ? $clog2(ROWS) : 1
) (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       cmd_valid_i,
  input  logic                       cmd_we_i,
  input  logic [wb_pkg::ADR_W-1:0]   cmd_adr_i,
  input  logic [wb_pkg::SEL_W-1:0]   cmd_sel_i,
  input  logic [wb_pkg::DAT_W-1:0]   cmd_data_i,
  output logic                       busy_o,
  output logic                       done_o,
  output logic [wb_pkg::DAT_W-1:0]   rd_data_o,
  input  logic                       frame_start_i,
  output logic                       cell_valid_o,
  output logic                       frame_done_o,
  output logic [ROW_W-1:0]           row_o,
  output logic [COL_W-1:0]           col_o,
  output logic [7:0]                 glyph_o,
  output logic [7:0]                 fg_o,
  output logic [7:0]                 bg_o,
  output logic [7:0]                 flags_o
);

  import wb_pkg::*;

  localparam int DEPTH = COLS * ROWS;

  // ====================
  // Bus wiring
  // ====================

  // Host bridge is master 0, scan reader is master 1.
  logic             h_cyc, h_stb, h_we, h_ack;
  logic [ADR_W-1:0] h_adr;
  logic [SEL_W-1:0] h_sel;
  logic [DAT_W-1:0] h_dat;

  logic             r_cyc, r_stb, r_we, r_ack;
  logic [ADR_W-1:0] r_adr;
  logic [SEL_W-1:0] r_sel;
  logic [DAT_W-1:0] r_dat;

  logic [DAT_W-1:0] m_dat;

  logic             s_cyc, s_stb, s_we, s_ack;
  logic [ADR_W-1:0] s_adr;
  logic [SEL_W-1:0] s_sel;
  logic [DAT_W-1:0] s_dat_w;
  logic [DAT_W-1:0] s_dat_r;

  host_bridge u_host (
    .clk(clk), .rst_n_i(rst_n_i),
    .cmd_valid_i(cmd_valid_i), .cmd_we_i(cmd_we_i), .cmd_adr_i(cmd_adr_i),
    .cmd_sel_i(cmd_sel_i), .cmd_data_i(cmd_data_i),
    .busy_o(busy_o), .done_o(done_o), .rd_data_o(rd_data_o),
    .cyc_o(h_cyc), .stb_o(h_stb), .we_o(h_we), .adr_o(h_adr), .sel_o(h_sel),
    .dat_o(h_dat), .ack_i(h_ack), .dat_i(m_dat)
  );

  scan_reader #(.COLS(COLS), .ROWS(ROWS)) u_scan (
    .clk(clk), .rst_n_i(rst_n_i), .frame_start_i(frame_start_i),
    .ack_i(r_ack), .dat_i(m_dat),
    .cell_valid_o(cell_valid_o), .frame_done_o(frame_done_o),
    .row_o(row_o), .col_o(col_o), .glyph_o(glyph_o), .fg_o(fg_o),
    .bg_o(bg_o), .flags_o(flags_o),
    .cyc_o(r_cyc), .stb_o(r_stb), .we_o(r_we), .adr_o(r_adr), .sel_o(r_sel),
    .dat_o(r_dat)
  );

  wb_arbiter u_arb (
    .clk(clk), .rst_n_i(rst_n_i),
    .m0_cyc_i(h_cyc), .m0_stb_i(h_stb), .m0_we_i(h_we), .m0_adr_i(h_adr),
    .m0_sel_i(h_sel), .m0_dat_i(h_dat),
    .m1_cyc_i(r_cyc), .m1_stb_i(r_stb), .m1_we_i(r_we), .m1_adr_i(r_adr),
    .m1_sel_i(r_sel), .m1_dat_i(r_dat),
    .m0_ack_o(h_ack), .m1_ack_o(r_ack), .m_dat_o(m_dat),
    .s_cyc_o(s_cyc), .s_stb_o(s_stb), .s_we_o(s_we), .s_adr_o(s_adr),
    .s_sel_o(s_sel), .s_dat_o(s_dat_w), .s_ack_i(s_ack), .s_dat_i(s_dat_r)
  );

  console_buffer #(.DEPTH(DEPTH)) u_buf (
    .clk(clk), .rst_n_i(rst_n_i),
    .cyc_i(s_cyc), .stb_i(s_stb), .we_i(s_we), .adr_i(s_adr), .sel_i(s_sel),
    .dat_i(s_dat_w), .ack_o(s_ack), .dat_o(s_dat_r)
  );

endmodule

`default_nettype wire

//--- hdl/host_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module host_bridge (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       cmd_valid_i,
  input  logic                       cmd_we_i,
  input  logic [wb_pkg::ADR_W-1:0]   cmd_adr_i,
  input  logic [wb_pkg::SEL_W-1:0]   cmd_sel_i,
  input  logic [wb_pkg::DAT_W-1:0]   cmd_data_i,
  output logic                       busy_o,
  output logic                       done_o,
  output logic [wb_pkg::DAT_W-1:0]   rd_data_o,
  output logic                       cyc_o,
  output logic                       stb_o,
  output logic                       we_o,
  output logic [wb_pkg::ADR_W-1:0]   adr_o,
  output logic [wb_pkg::SEL_W-1:0]   sel_o,
  output logic [wb_pkg::DAT_W-1:0]   dat_o,
  input  logic                       ack_i,
  input  logic [wb_pkg::DAT_W-1:0]   dat_i
);

  import wb_pkg::*;
  import console_pkg::*;

  logic             req_q;
  logic             done_q;
  logic             take_cmd;
  logic             ack_seen;
  logic             we_q;
  logic [ADR_W-1:0] adr_q;
  logic [SEL_W-1:0] sel_q;
  cell_t            data_q;
  cell_t            rd_q;

  assign take_cmd = cmd_valid_i & ~req_q;
  assign ack_seen = req_q & ack_i;

  // ====================
  // Command state
  // ====================

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      req_q  <= 1'b0;
      done_q <= 1'b0;
    end
    else
    begin
      done_q <= ack_seen;
      if (take_cmd)
      begin
        req_q <= 1'b1;
      end
      else if (ack_seen)
      begin
        req_q <= 1'b0;
      end
    end
  end

  // Holding registers keep the bus fields stable until ack.
  always_ff @(posedge clk)
  begin
    if (take_cmd)
    begin
      we_q   <= cmd_we_i;
      adr_q  <= cmd_adr_i;
      sel_q  <= cmd_sel_i;
      data_q <= cmd_data_i;
    end
    if (ack_seen && !we_q)
    begin
      rd_q <= dat_i;
    end
  end

  // The cycle closes in the same cycle that ack arrives.
  assign cyc_o = req_q & ~ack_i;
  assign stb_o = cyc_o;
  assign we_o  = we_q;
  assign adr_o = adr_q;
  assign sel_o = sel_q;
  assign dat_o = data_q;

  assign busy_o    = req_q;
  assign done_o    = done_q;
  assign rd_data_o = rd_q;

  a_no_cmd_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
    cmd_valid_i |-> !busy_o);

endmodule

`default_nettype wire

//--- hdl/scan_reader.sv
`timescale 1ns/1ps
`default_nettype none

module scan_reader #(
  parameter  int COLS  = console_pkg::COLS_DEF,
  parameter  int ROWS  = console_pkg::ROWS_DEF,
  localparam int COL_W = (COLS > 1) ? $clog2(COLS) : 1,
  localparam int ROW_W = (ROWS > 1) ? $clog2(ROWS) : 1
) (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       frame_start_i,
  input  logic                       ack_i,
  input  logic [wb_pkg::DAT_W-1:0]   dat_i,
  output logic                       cell_valid_o,
  output logic                       frame_done_o,
  output logic [ROW_W-1:0]           row_o,
  output logic [COL_W-1:0]           col_o,
  output logic [7:0]                 glyph_o,
  output logic [7:0]                 fg_o,
  output logic [7:0]                 bg_o,
  output logic [7:0]                 flags_o,
  output logic                       cyc_o,
  output logic                       stb_o,
  output logic                       we_o,
  output logic [wb_pkg::ADR_W-1:0]   adr_o,
  output logic [wb_pkg::SEL_W-1:0]   sel_o,
  output logic [wb_pkg::DAT_W-1:0]   dat_o
);

  import wb_pkg::*;
  import console_pkg::*;

  localparam int IDX_W = ADR_W - WORD_LSB;

  logic             active_q;
  logic [ROW_W-1:0] row_q;
  logic [COL_W-1:0] col_q;
  logic [IDX_W-1:0] cell_idx;
  logic             ack_seen;
  logic             last_col;
  logic             last_cell;
  cell_t            rd_cell;

  logic             valid_q;
  logic             done_q;
  logic [ROW_W-1:0] row_out_q;
  logic [COL_W-1:0] col_out_q;
  cell_fields_t     fields_q;

  assign ack_seen  = active_q & ack_i;
  assign last_col  = (col_q == COL_W'(COLS - 1));
  assign last_cell = last_col && (row_q == ROW_W'(ROWS - 1));
  assign rd_cell   = dat_i;

  // Row-major word index of the cell being fetched.
  assign cell_idx = IDX_W'(row_q) * IDX_W'(COLS) + IDX_W'(col_q);

  // ====================
  // Frame walk
  // ====================

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      active_q <= 1'b0;
      row_q    <= '0;
      col_q    <= '0;
      valid_q  <= 1'b0;
      done_q   <= 1'b0;
    end
    else
    begin
      valid_q <= ack_seen;
      done_q  <= ack_seen & last_cell;
      if (frame_start_i && !active_q)
      begin
        active_q <= 1'b1;
        row_q    <= '0;
        col_q    <= '0;
      end
      else if (ack_seen)
      begin
        if (last_cell)
        begin
          active_q <= 1'b0;
        end
        else if (last_col)
        begin
          col_q <= '0;
          row_q <= row_q + 1'b1;
        end
        else
        begin
          col_q <= col_q + 1'b1;
        end
      end
    end
  end

  // Stream registers, loaded from the field view of the acked word.
  always_ff @(posedge clk)
  begin
    if (ack_seen)
    begin
      fields_q  <= rd_cell.fields;
      row_out_q <= row_q;
      col_out_q <= col_q;
    end
  end

  assign cell_valid_o = valid_q;
  assign frame_done_o = done_q;
  assign row_o        = row_out_q;
  assign col_o        = col_out_q;
  assign glyph_o      = fields_q.glyph;
  assign fg_o         = fields_q.fg;
  assign bg_o         = fields_q.bg;
  assign flags_o      = fields_q.flags;

  // the reader only reads, and always the full word
  assign cyc_o = active_q & ~ack_i;
  assign stb_o = cyc_o;
  assign we_o  = 1'b0;
  assign adr_o = {cell_idx, {WORD_LSB{1'b0}}};
  assign sel_o = '1;
  assign dat_o = '0;

endmodule

`default_nettype wire

//--- hdl/wb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       m0_cyc_i,
  input  logic                       m0_stb_i,
  input  logic                       m0_we_i,
  input  logic [wb_pkg::ADR_W-1:0]   m0_adr_i,
  input  logic [wb_pkg::SEL_W-1:0]   m0_sel_i,
  input  logic [wb_pkg::DAT_W-1:0]   m0_dat_i,
  input  logic                       m1_cyc_i,
  input  logic                       m1_stb_i,
  input  logic                       m1_we_i,
  input  logic [wb_pkg::ADR_W-1:0]   m1_adr_i,
  input  logic [wb_pkg::SEL_W-1:0]   m1_sel_i,
  input  logic [wb_pkg::DAT_W-1:0]   m1_dat_i,
  output logic                       m0_ack_o,
  output logic                       m1_ack_o,
  output logic [wb_pkg::DAT_W-1:0]   m_dat_o,
  output logic                       s_cyc_o,
  output logic                       s_stb_o,
  output logic                       s_we_o,
  output logic [wb_pkg::ADR_W-1:0]   s_adr_o,
  output logic [wb_pkg::SEL_W-1:0]   s_sel_o,
  output logic [wb_pkg::DAT_W-1:0]   s_dat_o,
  input  logic                       s_ack_i,
  input  logic [wb_pkg::DAT_W-1:0]   s_dat_i
);

  // The grant is one-hot and falls to all zero when the bus is free.
  logic [1:0] gnt_q;
  logic [1:0] gnt_d;
  logic [1:0] req;
  logic       last_q;
  logic       owner_busy;

  assign req        = {m1_cyc_i, m0_cyc_i};
  assign owner_busy = |(gnt_q & req);

  // Re-arbitrate only once the owner has let go of cyc.
  always_comb
  begin
    gnt_d = gnt_q;
    if (!owner_busy)
    begin
      if (&req)
      begin
        gnt_d = last_q ? 2'b01 : 2'b10;
      end
      else
      begin
        gnt_d = req;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      gnt_q  <= 2'b00;
      last_q <= 1'b1;
    end
    else
    begin
      gnt_q <= gnt_d;
      if (gnt_d[1])
      begin
        last_q <= 1'b1;
      end
      else if (gnt_d[0])
      begin
        last_q <= 1'b0;
      end
    end
  end

  assign s_cyc_o = owner_busy;
  assign s_stb_o = (gnt_q[0] & m0_stb_i) | (gnt_q[1] & m1_stb_i);
  assign s_we_o  = gnt_q[1] ? m1_we_i  : m0_we_i;
  assign s_adr_o = gnt_q[1] ? m1_adr_i : m0_adr_i;
  assign s_sel_o = gnt_q[1] ? m1_sel_i : m0_sel_i;
  assign s_dat_o = gnt_q[1] ? m1_dat_i : m0_dat_i;

  assign m0_ack_o = s_ack_i & gnt_q[0];
  assign m1_ack_o = s_ack_i & gnt_q[1];
  assign m_dat_o  = s_dat_i;

  // The grant and the request it forwards stay put until the owner's ack.
  a_grant_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    owner_busy |=> ((gnt_q == $past(gnt_q)) && (s_we_o == $past(s_we_o)) &&
                    (s_adr_o == $past(s_adr_o)) && (s_sel_o == $past(s_sel_o)) &&
                    (s_dat_o == $past(s_dat_o))));

  // An ack answers the request that the same owner placed a cycle earlier.
  a_ack_owner: assert property (@(posedge clk) disable iff (!rst_n_i)
    s_ack_i |-> ($past(owner_busy && s_stb_o) && (gnt_q == $past(gnt_q))));

endmodule

`default_nettype wire

//--- hdl/wb_pkg.sv
`default_nettype none

// Widths shared by every agent on the console bus.
package wb_pkg;

  // Masters drive byte addresses. The slave indexes words.
  localparam int ADR_W = 32;
  localparam int DAT_W = 32;

  // One select bit per byte lane.
  localparam int SEL_W = DAT_W / 8;

  // Address bits below the word index.
  localparam int WORD_LSB = $clog2(SEL_W);

endpackage

`default_nettype wire

//--- sim.f
hdl/wb_pkg.sv
hdl/console_pkg.sv
hdl/console_buffer.sv
hdl/wb_arbiter.sv
hdl/host_bridge.sv
hdl/scan_reader.sv
hdl/console_top.sv
test/tb_console.sv

//--- test/console_input.txt
# Columns: test name, op (W write, R read, X random fill, F frame scan), then hex fields.
# W adr sel data | R adr [expected, else model] | X | F host_reads second_pulse
full_wr0      W 00000000 f 1f074120
full_rd0      R 00000000 1f074120
full_wr1      W 000000ec f 00ff8142
full_rd1      R 000000ec 00ff8142
full_wr2      W 00000054 f a5c3e711
full_rd2      R 00000054 a5c3e711
merge_base    W 00000010 f 11223344
merge_lane0   W 00000010 1 000000aa
merge_rd0     R 00000010 112233aa
merge_lane3   W 00000010 8 bb000000
merge_rd1     R 00000010 bb2233aa
merge_mid     W 00000010 6 00cdef00
merge_rd2     R 00000010 bbcdefaa
merge_none    W 00000010 0 ffffffff
merge_rd3     R 00000010 bbcdefaa
merge_hi      W 00000014 f 00000000
merge_hi_sel  W 00000014 c 12345678
merge_rd4     R 00000014 12340000
fill_random   X
frame_plain   F 0 0
frame_contend F 8 0
frame_repulse F 0 1
patch_glyph   W 00000000 1 00000058
patch_flags   W 0000003c 8 80000000
patch_rd0     R 00000000
patch_rd1     R 0000003c
frame_patched F 4 1
frame_busy    F 10 1

//--- test/tb_console.sv
`timescale 1ns/1ps
`default_nettype none

module tb_console;

  import wb_pkg::*;
  import console_pkg::*;

  localparam int    COLS      = 10;
  localparam int    ROWS      = 6;
  localparam int    DEPTH     = COLS * ROWS;
  localparam int    COL_W     = $clog2(COLS);
  localparam int    ROW_W     = $clog2(ROWS);
  localparam string DATA_FILE = "test/console_input.txt";

  logic             clk;
  logic             rst_n_i;
  logic             cmd_valid_i;
  logic             cmd_we_i;
  logic [ADR_W-1:0] cmd_adr_i;
  logic [SEL_W-1:0] cmd_sel_i;
  logic [DAT_W-1:0] cmd_data_i;
  logic             busy_o;
  logic             done_o;
  logic [DAT_W-1:0] rd_data_o;
  logic             frame_start_i;
  logic             cell_valid_o;
  logic             frame_done_o;
  logic [ROW_W-1:0] row_o;
  logic [COL_W-1:0] col_o;
  logic [7:0]       glyph_o;
  logic [7:0]       fg_o;
  logic [7:0]       bg_o;
  logic [7:0]       flags_o;

  // Reference copy of the screen, merged lane by lane on every write.
  cell_t model [DEPTH];
  int    seed;
  int    errors;
  int    test_errors;
  int    tests_run;
  int    tests_failed;
  int    cells_seen;
  int    cycles;
  int    cycle_limit;

  console_top #(.COLS(COLS), .ROWS(ROWS)) DUT (
    .clk(clk), .rst_n_i(rst_n_i),
    .cmd_valid_i(cmd_valid_i), .cmd_we_i(cmd_we_i), .cmd_adr_i(cmd_adr_i),
    .cmd_sel_i(cmd_sel_i), .cmd_data_i(cmd_data_i),
    .busy_o(busy_o), .done_o(done_o), .rd_data_o(rd_data_o),
    .frame_start_i(frame_start_i), .cell_valid_o(cell_valid_o),
    .frame_done_o(frame_done_o), .row_o(row_o), .col_o(col_o),
    .glyph_o(glyph_o), .fg_o(fg_o), .bg_o(bg_o), .flags_o(flags_o)
  );

  always #10 clk = ~clk;

  // ====================
  // Checks
  // ====================

  task automatic count_error();
    errors++;
    test_errors++;
  endtask

  task automatic check_word(input string name, input cell_t exp, input cell_t act);
    if (act !== exp)
    begin
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
      count_error();
    end
  endtask

  task automatic check_cell(input string name, input cell_fields_t exp,
                            input cell_fields_t act);
    if (act !== exp)
    begin
      $display("FAILED %s: expected glyph %h fg %h bg %h flags %h, %s",
               name, exp.glyph, exp.fg, exp.bg, exp.flags,
               $sformatf("actual glyph %h fg %h bg %h flags %h",
                         act.glyph, act.fg, act.bg, act.flags));
      count_error();
    end
  endtask

  task automatic check_pos(input string name, input logic [ROW_W-1:0] exp_row,
                           input logic [COL_W-1:0] exp_col, input logic [ROW_W-1:0] act_row,
                           input logic [COL_W-1:0] act_col);
    if (act_row !== exp_row || act_col !== exp_col)
    begin
      $display("FAILED %s: expected row %0d col %0d, actual row %0d col %0d",
               name, exp_row, exp_col, act_row, act_col);
      count_error();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("FAILED %s: expected %b, actual %b", name, exp, act);
      count_error();
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp)
    begin
      $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
      count_error();
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors == 0)
    begin
      $display("[pass] %s", name);
    end
    else
    begin
      tests_failed++;
      $display("[fail] %s with %0d errors", name, test_errors);
    end
  endtask

  // ====================
  // Stimulus
  // ====================

  task automatic model_write(input int idx, input logic [SEL_W-1:0] sel, input cell_t data);
    for (int lane = 0; lane < SEL_W; lane++)
    begin
      if (sel[lane])
      begin
        model[idx].bytes[lane] = data.bytes[lane];
      end
    end
  endtask

  // Called on a falling edge. Returns on the falling edge where done_o is seen.
  task automatic host_cmd(input logic we, input logic [ADR_W-1:0] adr,
                          input logic [SEL_W-1:0] sel, input logic [DAT_W-1:0] data,
                          input string name, output cell_t rd);
    cmd_valid_i = 1'b1;
    cmd_we_i    = we;
    cmd_adr_i   = adr;
    cmd_sel_i   = sel;
    cmd_data_i  = data;
    @(negedge clk);
    cmd_valid_i = 1'b0;
    check_flag({name, "/busy_o"}, 1'b1, busy_o);
    while (!done_o)
    begin
      @(negedge clk);
    end
    rd = rd_data_o;
  endtask

  task automatic fill_random(input string name);
    cell_t word;
    cell_t rd;
    for (int idx = 0; idx < DEPTH; idx++)
    begin
      word = $random(seed);
      host_cmd(1'b1, ADR_W'(idx * 4), '1, word, name, rd);
      model_write(idx, '1, word);
    end
  endtask

  task automatic host_reads(input string name, input int count);
    int    idx;
    cell_t rd;
    for (int i = 0; i < count; i++)
    begin
      idx = $unsigned($random(seed)) % DEPTH;
      host_cmd(1'b0, ADR_W'(idx * 4), '1, '0, name, rd);
      check_word({name, "/host"}, model[idx], rd);
    end
  endtask

  task automatic scan_collect(input string name);
    cell_fields_t act;
    logic         finished;
    finished = 1'b0;
    while (!finished)
    begin
      @(negedge clk);
      if (cell_valid_o)
      begin
        if (cells_seen < DEPTH)
        begin
          act = '{flags: flags_o, bg: bg_o, fg: fg_o, glyph: glyph_o};
          check_pos(name, ROW_W'(cells_seen / COLS), COL_W'(cells_seen % COLS), row_o, col_o);
          check_cell(name, model[cells_seen].fields, act);
        end
        cells_seen++;
      end
      if (frame_done_o)
      begin
        // The done pulse belongs to the last cell.
        check_flag({name, "/last_cell"}, 1'b1, cell_valid_o);
        check_count({name, "/cells"}, DEPTH, cells_seen);
        finished = 1'b1;
      end
    end
  endtask

  task automatic run_frame(input string name, input int reads, input logic repulse);
    cells_seen = 0;
    fork
      scan_collect(name);
      host_reads(name, reads);
      begin
        frame_start_i = 1'b1;
        @(negedge clk);
        frame_start_i = 1'b0;
        if (repulse)
        begin
          wait (cells_seen >= 3);
          @(negedge clk);
          frame_start_i = 1'b1;
          @(negedge clk);
          frame_start_i = 1'b0;
        end
      end
    join
    // An extra pulse must not have started a second walk.
    repeat (8)
    begin
      @(negedge clk);
      check_flag({name, "/idle"}, 1'b0, cell_valid_o);
    end
  endtask

  task automatic run_line(input string line);
    logic [8*24-1:0] name_r;
    logic [8*4-1:0]  op;
    logic [31:0]     f0;
    logic [31:0]     f1;
    logic [31:0]     f2;
    string           name;
    int              n;
    int              idx;
    cell_t           exp;
    cell_t           rd;
    f0 = '0;
    f1 = '0;
    f2 = '0;
    n = $sscanf(line, "%s %s %h %h %h", name_r, op, f0, f1, f2);
    name = $sformatf("%0s", name_r);
    idx = int'(f0 >> WORD_LSB);
    test_errors = 0;
    case (op)
      "W":
      begin
        host_cmd(1'b1, f0, f1[SEL_W-1:0], f2, name, rd);
        model_write(idx, f1[SEL_W-1:0], f2);
      end
      "R":
      begin
        if (n >= 4)
        begin
          exp = f1;
        end
        else
        begin
          exp = model[idx];
        end
        host_cmd(1'b0, f0, '1, '0, name, rd);
        check_word(name, exp, rd);
      end
      "X": fill_random(name);
      "F": run_frame(name, int'(f0), f1[0]);
      default:
      begin
        $display("Unknown op %0s in test %s", op, name);
        count_error();
      end
    endcase
    finish_test(name);
  endtask

  function automatic bit is_test_line(input string line);
    logic [8*24-1:0] tok0;
    logic [8*4-1:0]  tok1;
    if (line.len() == 0 || line[0] == "#")
    begin
      return 1'b0;
    end
    return $sscanf(line, "%s %s", tok0, tok1) == 2;
  endfunction

  function automatic int count_tests();
    int    fd;
    int    count;
    string line;
    count = 0;
    fd = $fopen(DATA_FILE, "r");
    if (fd != 0)
    begin
      while ($fgets(line, fd) != 0)
      begin
        if (is_test_line(line))
        begin
          count++;
        end
      end
      $fclose(fd);
    end
    return count;
  endfunction

  // ====================
  // Run control
  // ====================

  initial
  begin
    wait (cycle_limit > 0);
    while (cycles < cycle_limit)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not end within %0d cycles", cycle_limit);
    $display("Something failed");
    $finish;
  end

  initial
  begin
    int    fd;
    int    lines;
    string line;
    clk           = 1'b0;
    rst_n_i       = 1'b0;
    cmd_valid_i   = 1'b0;
    cmd_we_i      = 1'b0;
    cmd_adr_i     = '0;
    cmd_sel_i     = '0;
    cmd_data_i    = '0;
    frame_start_i = 1'b0;
    seed          = 32'h5866;
    errors        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    cycles        = 0;
    lines = count_tests();
    cycle_limit = ((lines > 0) ? lines : 1) * COLS * ROWS * 8;

    repeat (10) @(negedge clk);
    rst_n_i = 1'b1;
    @(negedge clk);
    test_errors = 0;
    check_flag("reset_idle/busy_o", 1'b0, busy_o);
    check_flag("reset_idle/done_o", 1'b0, done_o);
    check_flag("reset_idle/cell_valid_o", 1'b0, cell_valid_o);
    check_flag("reset_idle/frame_done_o", 1'b0, frame_done_o);
    finish_test("reset_idle");

    fd = $fopen(DATA_FILE, "r");
    if (fd == 0)
    begin
      $display("Cannot open the test data file %s", DATA_FILE);
      count_error();
    end
    else
    begin
      while ($fgets(line, fd) != 0)
      begin
        if (is_test_line(line))
        begin
          run_line(line);
        end
      end
      $fclose(fd);
    end

    $display("Tests run %0d, passed %0d, failed %0d, check errors %0d",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0)
    begin
      $display("Everything OK");
    end
    else
    begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
